//--- hdl/array_geometry_pkg.sv
package array_geometry_pkg;

    // array size
    localparam int num_columns = 8;
    localparam int num_rows    = 8;

    // fifo and weight memory words
    localparam int word_width = 64;
    localparam int addr_width = 32;
    localparam int wmem_words = 2048;

    // lane counters need one extra bit to hold the lane count itself
    localparam int lane_idx_width = $clog2(num_columns) + 1;

    // weight address split, low bits select the row, the rest is the page
    localparam int row_bits   = $clog2(num_rows);
    localparam int page_width = addr_width - row_bits;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [addr_width-1:0]     wm_addr_t;
    typedef logic [page_width-1:0]     wm_page_t;
    typedef logic [lane_idx_width-1:0] lane_idx_t;

    // lane 0 sits in the lowest word
    typedef logic [num_columns*word_width-1:0] column_bus_t;
    typedef logic [num_rows*word_width-1:0]    row_bus_t;

    typedef logic [num_columns-1:0] column_mask_t;
    typedef logic [num_rows-1:0]    row_mask_t;

endpackage

//--- hdl/lane_load_bank.sv
`timescale 1ns/1ps

module lane_load_bank
    import array_geometry_pkg::*;
#(
    parameter int lanes = num_columns
)
(
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        load,
    input  logic [lanes-1:0]            lane_mask,
    input  lane_idx_t                   lane_sel,
    input  word_t                       data_in,
    output logic [lanes*word_width-1:0] lanes_out
);

    // one word per lane, lane 0 in the low word
    word_t [lanes-1:0] lane_q;

    //////////////////////////////////////////////////////////////////////
    // steer the incoming word into the selected lane
    //////////////////////////////////////////////////////////////////////

    // only the lane picked by lane_sel takes the word, every other lane
    // keeps what it captured last time
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int j = 0; j < lanes; j++) begin
                lane_q[j] <= '0;
            end
        end else if (load) begin
            for (int j = 0; j < lanes; j++) begin
                // masked-off lanes stay frozen for the current precision
                if (lane_mask[j] && (lane_sel == lane_idx_t'(j))) begin
                    lane_q[j] <= data_in;
                end
            end
        end
    end

    // straight to the mxu, no filtering
    assign lanes_out = lane_q;

endmodule

//--- hdl/ls_array.sv
`timescale 1ns/1ps

module ls_array
    import array_geometry_pkg::*, ls_control_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  precision_e  precision,
    input  ls_cmd_t     cmd,
    input  wgen_cmd_t   wgen_cmd,
    input  lane_idx_t   max_cnt_from_cu,
    input  lane_idx_t   max_cnt_weight_from_cu,
    input  wm_addr_t    start_value_wm,
    input  word_t       input_data_from_fifo,
    input  word_t       data_from_weight_memory,
    input  column_bus_t data_from_mxu,
    output column_bus_t data_to_mxu,
    output row_bus_t    weight_to_mxu,
    output word_t       data_to_fifo_out,
    output wm_addr_t    wm_address
);

    column_mask_t column_mask;
    row_mask_t    row_mask;
    lane_idx_t    lane_sel;
    lane_idx_t    row_index;
    logic         array_active;

    // precision decode and activation lane counter
    ls_control u_control (
        .clk             (clk),
        .reset_n         (reset_n),
        .precision       (precision),
        .cmd             (cmd),
        .max_cnt_from_cu (max_cnt_from_cu),
        .column_mask     (column_mask),
        .row_mask        (row_mask),
        .lane_sel        (lane_sel),
        .array_active    (array_active)
    );

    //////////////////////////////////////////////////////////////////////
    // load side, columns from the input fifo, rows from weight memory
    //////////////////////////////////////////////////////////////////////
    lane_load_bank #(.lanes(num_columns)) u_activation_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .load      (cmd.infifo_read),
        .lane_mask (column_mask),
        .lane_sel  (lane_sel),
        .data_in   (input_data_from_fifo),
        .lanes_out (data_to_mxu)
    );

    lane_load_bank #(.lanes(num_rows)) u_weight_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .load      (cmd.read_weight_memory),
        .lane_mask (row_mask),
        .lane_sel  (row_index),
        .data_in   (data_from_weight_memory),
        .lanes_out (weight_to_mxu)
    );

    //////////////////////////////////////////////////////////////////////
    // store side and weight addressing
    //////////////////////////////////////////////////////////////////////
    result_store_bank u_store_bank (
        .clk              (clk),
        .reset_n          (reset_n),
        .store            (cmd.enable_store_activation_data),
        .outfifo_write    (cmd.outfifo_write),
        .column_mask      (column_mask),
        .lane_sel         (lane_sel),
        .data_from_mxu    (data_from_mxu),
        .data_to_fifo_out (data_to_fifo_out)
    );

    weight_address_gen u_weight_addr (
        .clk                    (clk),
        .reset_n                (reset_n),
        .count_enable           (array_active),
        .wgen_cmd               (wgen_cmd),
        .max_cnt_weight_from_cu (max_cnt_weight_from_cu),
        .start_value_wm         (start_value_wm),
        .row_index              (row_index),
        .wm_address             (wm_address)
    );

endmodule

//--- hdl/ls_control.sv
`timescale 1ns/1ps

module ls_control
    import array_geometry_pkg::*, ls_control_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  precision_e   precision,
    input  ls_cmd_t      cmd,
    input  lane_idx_t    max_cnt_from_cu,
    output column_mask_t column_mask,
    output row_mask_t    row_mask,
    output lane_idx_t    lane_sel,
    output logic         array_active
);

    logic [6:0] prec_bits;
    lane_idx_t  active_cols;
    lane_idx_t  active_rows;
    lane_idx_t  lane_cnt;
    lane_idx_t  max_cnt;

    //////////////////////////////////////////////////////////////////////
    // precision decoder
    //////////////////////////////////////////////////////////////////////

    // element width, zero while the array is idle so no lane toggles
    always_comb begin
        prec_bits = 7'd0;
        if (cmd.enable_load_array) begin
            case (precision)
                int8:    prec_bits = 7'd8;
                int16:   prec_bits = 7'd16;
                int32:   prec_bits = 7'd32;
                int64:   prec_bits = 7'd64;
                default: prec_bits = 7'd0;
            endcase
        end
    end

    // lanes x bits / 64 lanes carry data
    assign active_cols = lane_idx_t'(num_columns * prec_bits / word_width);
    assign active_rows = lane_idx_t'(num_rows * prec_bits / word_width);

    always_comb begin
        for (int j = 0; j < num_columns; j++) begin
            column_mask[j] = (lane_idx_t'(j) < active_cols);
        end
    end

    always_comb begin
        for (int j = 0; j < num_rows; j++) begin
            row_mask[j] = (lane_idx_t'(j) < active_rows);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // activation lane counter
    //////////////////////////////////////////////////////////////////////

    // wraps after max_cnt-1, drops back to lane 0 whenever counting stops
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lane_cnt <= '0;
            max_cnt  <= '0;
        end else if (cmd.enable_load_array) begin
            if (cmd.enable_cnt) begin
                if (lane_cnt == max_cnt - 1'b1) begin
                    lane_cnt <= '0;
                end else begin
                    lane_cnt <= lane_cnt + 1'b1;
                end
            end else begin
                lane_cnt <= '0;
            end

            if (cmd.ld_max_cnt) begin
                max_cnt <= max_cnt_from_cu;
            end
        end
    end

    assign lane_sel = lane_cnt;

    // the weight generator only counts while the array is on
    assign array_active = cmd.enable_load_array;

endmodule

//--- hdl/ls_control_pkg.sv
package ls_control_pkg;

    // element size inside a 64-bit word
    typedef enum logic [1:0] {
        int8  = 2'd0,
        int16 = 2'd1,
        int32 = 2'd2,
        int64 = 2'd3
    } precision_e;

    //////////////////////////////////////////////////////////////////////
    // strobes from the control unit to the load/store array
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic enable_load_array;
        logic enable_cnt;
        logic ld_max_cnt;
        logic enable_store_activation_data;
        logic infifo_read;
        logic outfifo_write;
        logic read_weight_memory;
    } ls_cmd_t;

    //////////////////////////////////////////////////////////////////////
    // strobes for the weight address generator
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        // steps the row counter and drives the address out
        logic enable_cnt_weight;
        logic ld_max_cnt_weight;
        // page preload from start_value_wm
        logic ld_weight_page_cnt;
    } wgen_cmd_t;

endpackage

//--- hdl/result_store_bank.sv
`timescale 1ns/1ps

module result_store_bank
    import array_geometry_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  logic         store,
    input  logic         outfifo_write,
    input  column_mask_t column_mask,
    input  lane_idx_t    lane_sel,
    input  column_bus_t  data_from_mxu,
    output word_t        data_to_fifo_out
);

    word_t [num_columns-1:0] store_q;

    //////////////////////////////////////////////////////////////////////
    // capture mxu results
    //////////////////////////////////////////////////////////////////////

    // all active columns land in the same cycle
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int j = 0; j < num_columns; j++) begin
                store_q[j] <= '0;
            end
        end else if (store) begin
            for (int j = 0; j < num_columns; j++) begin
                if (column_mask[j]) begin
                    store_q[j] <= data_from_mxu[j*word_width +: word_width];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output fifo read mux
    //////////////////////////////////////////////////////////////////////

    // one column per cycle as the lane counter walks, idle bus is zero
    always_comb begin
        data_to_fifo_out = '0;
        if (outfifo_write) begin
            for (int j = 0; j < num_columns; j++) begin
                if (lane_sel == lane_idx_t'(j)) begin
                    data_to_fifo_out = store_q[j];
                end
            end
        end
    end

endmodule

//--- hdl/weight_address_gen.sv
`timescale 1ns/1ps

module weight_address_gen
    import array_geometry_pkg::*, ls_control_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      count_enable,
    input  wgen_cmd_t wgen_cmd,
    input  lane_idx_t max_cnt_weight_from_cu,
    input  wm_addr_t  start_value_wm,
    output lane_idx_t row_index,
    output wm_addr_t  wm_address
);

    lane_idx_t row_cnt;
    lane_idx_t max_cnt_weight;
    wm_page_t  page_cnt;
    wm_addr_t  composed_addr;

    // page on top, low row bits underneath
    assign composed_addr = {page_cnt, row_cnt[row_bits-1:0]};

    //////////////////////////////////////////////////////////////////////
    // row and page counters
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            row_cnt        <= '0;
            page_cnt       <= '0;
            max_cnt_weight <= '0;
        end else if (count_enable) begin
            if (wgen_cmd.enable_cnt_weight) begin
                // row wrap moves on to the next page
                if (row_cnt == max_cnt_weight - 1'b1) begin
                    row_cnt  <= '0;
                    page_cnt <= page_cnt + 1'b1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end

                // end of the weight memory, start over at address 0
                if (composed_addr == wm_addr_t'(wmem_words - 1)) begin
                    row_cnt  <= '0;
                    page_cnt <= '0;
                end
            end

            if (wgen_cmd.ld_max_cnt_weight) begin
                max_cnt_weight <= max_cnt_weight_from_cu;
            end

            // preload wins over the count step
            if (wgen_cmd.ld_weight_page_cnt) begin
                page_cnt <= start_value_wm[addr_width-1:row_bits];
            end
        end
    end

    // also picks the row register for the incoming memory word
    assign row_index = row_cnt;

    // address bus held at zero outside a weight fetch
    assign wm_address = wgen_cmd.enable_cnt_weight ? composed_addr : '0;

endmodule

//--- ls_array.f
hdl/array_geometry_pkg.sv
hdl/ls_control_pkg.sv
hdl/ls_control.sv
hdl/lane_load_bank.sv
hdl/result_store_bank.sv
hdl/weight_address_gen.sv
hdl/ls_array.sv
testbench/ls_array_sva.sv
testbench/tb_ls_array.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ls_array testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f ls_array.f --top-module tb_ls_array -o sim_ls_array

sim_out=$(./obj_dir/sim_ls_array)
echo "$sim_out"

if echo "$sim_out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

//--- testbench/ls_array_sva.sv
`timescale 1ns/1ps

module ls_array_sva
    import array_geometry_pkg::*, ls_control_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input ls_cmd_t   cmd,
    input wgen_cmd_t wgen_cmd,
    input lane_idx_t max_cnt_from_cu,
    input lane_idx_t lane_sel,
    input word_t     data_to_fifo_out,
    input wm_addr_t  wm_address
);

    // last max_cnt accepted by the array
    lane_idx_t loaded_max;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            loaded_max <= '0;
        end else if (cmd.enable_load_array && cmd.ld_max_cnt) begin
            loaded_max <= max_cnt_from_cu;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus idle values and counter range
    //////////////////////////////////////////////////////////////////////
    addr_idle_zero: assert property (@(posedge clk) disable iff (!reset_n)
        !wgen_cmd.enable_cnt_weight |-> (wm_address == '0))
        else $error("wm_address not zero while enable_cnt_weight is low");

    fifo_out_idle_zero: assert property (@(posedge clk) disable iff (!reset_n)
        !cmd.outfifo_write |-> (data_to_fifo_out == '0))
        else $error("data_to_fifo_out not zero without outfifo_write");

    lane_below_max: assert property (@(posedge clk) disable iff (!reset_n)
        (loaded_max == '0) || (lane_sel < loaded_max))
        else $error("lane counter reached max_cnt");

endmodule

bind ls_array ls_array_sva u_sva (
    .clk              (clk),
    .reset_n          (reset_n),
    .cmd              (cmd),
    .wgen_cmd         (wgen_cmd),
    .max_cnt_from_cu  (max_cnt_from_cu),
    .lane_sel         (lane_sel),
    .data_to_fifo_out (data_to_fifo_out),
    .wm_address       (wm_address)
);

//--- testbench/tb_ls_array.sv
`timescale 1ns/1ps

module tb_ls_array
    import array_geometry_pkg::*, ls_control_pkg::*;
();

    typedef struct packed {
        precision_e prec;
        lane_idx_t  lanes;
    } prec_row_t;

    logic        clk;
    logic        reset_n;
    precision_e  precision;
    ls_cmd_t     cmd;
    wgen_cmd_t   wgen_cmd;
    lane_idx_t   max_cnt_from_cu;
    lane_idx_t   max_cnt_weight_from_cu;
    wm_addr_t    start_value_wm;
    word_t       input_data_from_fifo;
    word_t       data_from_weight_memory;
    column_bus_t data_from_mxu;
    column_bus_t data_to_mxu;
    row_bus_t    weight_to_mxu;
    word_t       data_to_fifo_out;
    wm_addr_t    wm_address;

    prec_row_t   prec_table [4];
    int          errors;
    int          checks;
    int          tests;
    int          exp_row;
    int          exp_page;
    word_t       last_mxu_lane0;
    column_bus_t last_activation;

    ls_array uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hard stop in case a loop never returns
    initial begin
        #200us;
        $display("timeout: simulation did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic compare(input string name, input logic [511:0] actual,
                           input logic [511:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input int num, input string title, input int err_before);
        tests++;
        $display("test %0d %s: %0d errors", num, title, errors - err_before);
    endtask

    function automatic ls_cmd_t array_cmd();
        ls_cmd_t c;
        c = '0;
        c.enable_load_array = 1'b1;
        return c;
    endfunction

    function automatic word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // row steps each count, page steps on row wrap, whole address wraps at the top
    task automatic advance_weight_model();
        if (exp_page * num_rows + exp_row == wmem_words - 1) begin
            exp_row  = 0;
            exp_page = 0;
        end else if (exp_row == num_rows - 1) begin
            exp_row = 0;
            exp_page++;
        end else begin
            exp_row++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // per-precision tests
    //////////////////////////////////////////////////////////////////////
    task automatic activation_load(input int row);
        word_t       words [num_columns];
        column_bus_t exp_bus;
        ls_cmd_t     c;
        lane_idx_t   n;
        int          e0;
        e0 = errors;
        n = prec_table[row].lanes;
        @(posedge clk);
        precision <= prec_table[row].prec;
        c = array_cmd();
        c.ld_max_cnt = 1'b1;
        cmd <= c;
        max_cnt_from_cu <= lane_idx_t'(8);
        for (int k = 0; k < num_columns; k++) begin
            words[k] = rand_word();
            @(posedge clk);
            c = array_cmd();
            c.enable_cnt = 1'b1;
            c.infifo_read = 1'b1;
            cmd <= c;
            input_data_from_fifo <= words[k];
        end
        @(posedge clk);
        cmd <= array_cmd();
        input_data_from_fifo <= '0;
        for (int j = 0; j < num_columns; j++) begin
            exp_bus[j*word_width +: word_width] = (j < n) ? words[j] : word_t'(0);
        end
        @(negedge clk);
        for (int j = 0; j < num_columns; j++) begin
            compare($sformatf("data_to_mxu[%0d]", j), data_to_mxu[j*word_width +: word_width],
                    exp_bus[j*word_width +: word_width]);
        end
        last_activation = exp_bus;
        report_test(2, $sformatf("activation load, %0d lanes", n), e0);
    endtask

    task automatic store_readout(input int row);
        word_t       words [num_columns];
        column_bus_t bus;
        ls_cmd_t     c;
        lane_idx_t   n;
        int          e0;
        e0 = errors;
        n = prec_table[row].lanes;
        for (int j = 0; j < num_columns; j++) begin
            words[j] = rand_word();
            bus[j*word_width +: word_width] = words[j];
        end
        last_mxu_lane0 = words[0];
        @(posedge clk);
        c = array_cmd();
        c.enable_store_activation_data = 1'b1;
        cmd <= c;
        data_from_mxu <= bus;
        @(posedge clk);
        c = array_cmd();
        c.enable_cnt = 1'b1;
        c.outfifo_write = 1'b1;
        cmd <= c;
        data_from_mxu <= '0;
        for (int k = 0; k < num_columns; k++) begin
            @(negedge clk);
            compare($sformatf("data_to_fifo_out lane %0d", k), data_to_fifo_out,
                    (k < n) ? words[k] : word_t'(0));
            if (k < num_columns - 1) begin
                @(posedge clk);
            end
        end
        @(posedge clk);
        cmd <= array_cmd();
        report_test(3, $sformatf("result store and readout, %0d lanes", n), e0);
    endtask

    task automatic weight_load(input int row);
        word_t     expected [num_rows];
        word_t     w_word;
        wgen_cmd_t w;
        ls_cmd_t   c;
        lane_idx_t n;
        int        e0;
        e0 = errors;
        n = prec_table[row].lanes;
        for (int j = 0; j < num_rows; j++) begin
            expected[j] = '0;
        end
        @(posedge clk);
        cmd <= array_cmd();
        w = '0;
        w.ld_max_cnt_weight = 1'b1;
        wgen_cmd <= w;
        max_cnt_weight_from_cu <= lane_idx_t'(8);
        for (int k = 0; k < num_rows; k++) begin
            w_word = rand_word();
            @(posedge clk);
            c = array_cmd();
            c.read_weight_memory = 1'b1;
            cmd <= c;
            w = '0;
            w.enable_cnt_weight = 1'b1;
            wgen_cmd <= w;
            data_from_weight_memory <= w_word;
            @(negedge clk);
            compare("wm_address", wm_address, wm_addr_t'(exp_page * num_rows + exp_row));
            if (exp_row < n) begin
                expected[exp_row] = w_word;
            end
            advance_weight_model();
        end
        @(posedge clk);
        cmd <= array_cmd();
        wgen_cmd <= '0;
        data_from_weight_memory <= '0;
        @(negedge clk);
        for (int j = 0; j < num_rows; j++) begin
            compare($sformatf("weight_to_mxu[%0d]", j),
                    weight_to_mxu[j*word_width +: word_width], expected[j]);
        end
        report_test(4, $sformatf("weight load and address, %0d rows", n), e0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int        seed_ret;
        int        e0;
        ls_cmd_t   c;
        wgen_cmd_t w;
        reset_n = 1'b0;
        precision = int8;
        cmd = '0;
        wgen_cmd = '0;
        max_cnt_from_cu = '0;
        max_cnt_weight_from_cu = '0;
        start_value_wm = '0;
        input_data_from_fifo = '0;
        data_from_weight_memory = '0;
        data_from_mxu = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        exp_row = 0;
        exp_page = 0;
        last_mxu_lane0 = '0;
        last_activation = '0;
        seed_ret = $urandom(32'hc5a198a0);
        prec_table[0] = '{int8, lane_idx_t'(1)};
        prec_table[1] = '{int16, lane_idx_t'(2)};
        prec_table[2] = '{int32, lane_idx_t'(4)};
        prec_table[3] = '{int64, lane_idx_t'(8)};

        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);

        e0 = errors;
        compare("data_to_mxu", data_to_mxu, '0);
        compare("weight_to_mxu", weight_to_mxu, '0);
        compare("data_to_fifo_out", data_to_fifo_out, '0);
        compare("wm_address", wm_address, '0);
        report_test(1, "reset", e0);

        // lane counts rise row by row, so upper lanes are still at reset
        for (int r = 0; r < 4; r++) begin
            activation_load(r);
            store_readout(r);
            weight_load(r);
        end

        e0 = errors;
        @(posedge clk);
        cmd <= array_cmd();
        w = '0;
        w.ld_weight_page_cnt = 1'b1;
        wgen_cmd <= w;
        start_value_wm <= wm_addr_t'(wmem_words - 8);
        for (int k = 0; k < 9; k++) begin
            @(posedge clk);
            w = '0;
            w.enable_cnt_weight = 1'b1;
            wgen_cmd <= w;
            @(negedge clk);
            compare("wm_address", wm_address,
                    (k == 8) ? wm_addr_t'(0) : wm_addr_t'(wmem_words - 8 + k));
        end
        @(posedge clk);
        wgen_cmd <= '0;
        report_test(5, "page preload and wrap", e0);

        e0 = errors;
        for (int k = 0; k < 6; k++) begin
            @(posedge clk);
            c = '0;
            c.enable_cnt = 1'b1;
            c.infifo_read = 1'b1;
            c.outfifo_write = 1'b1;
            c.ld_max_cnt = 1'b1;
            cmd <= c;
            max_cnt_from_cu <= lane_idx_t'(3);
            input_data_from_fifo <= rand_word();
            @(negedge clk);
            compare("data_to_mxu", data_to_mxu, last_activation);
            compare("data_to_fifo_out", data_to_fifo_out, last_mxu_lane0);
        end
        @(posedge clk);
        cmd <= '0;
        report_test(6, "disabled array", e0);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
